// File: compile.f
+incdir+testbench
design/mipsDecodePkg.sv
design/mainDecoder.sv
design/aluDecoder.sv
design/controller.sv
design/decodeUnit.sv
testbench/tb_decodeUnit.sv

// File: Bender.yml
package:
  name: mips_decode

sources:
  - design/mipsDecodePkg.sv
  - design/mainDecoder.sv
  - design/aluDecoder.sv
  - design/controller.sv
  - design/decodeUnit.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_decodeUnit.sv

// File: testbench/decodeRef.svh
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// expected outputs of the decode unit for one word
typedef struct packed {
    logic        regWrite;
    logic        regDst;
    logic        aluSrc;
    logic        branch;
    logic        bal;
    logic        memWrite;
    logic        memToReg;
    logic        jump;
    aluOp_e      aluOp;
    branchCond_e brCond;
    logic [31:0] immExt;
    logic [4:0]  writeReg;
} decodeExp_t;

// expected decode, built opcode by opcode
function automatic decodeExp_t decodeRef(instrWord_u w);
    decodeExp_t e;
    logic [4:0] dest;
    opcode_e    op;
    op = w.iFields.op;
    e = '0;
    e.aluOp = ALU_NONE;
    e.brCond = BR_NONE;
    // sign extension unless a logical immediate overrides it
    e.immExt = {{16{w.iFields.imm16[15]}}, w.iFields.imm16};
    dest = w.iFields.rt;
    case (op)
        RTYPE: begin
            e.regDst = 1'b1;
            e.regWrite = 1'b1;
            dest = w.rFields.rd;
            case (w.rFields.funct)
                F_ADD, F_ADDU: e.aluOp = ALU_ADD;
                F_SUB, F_SUBU: e.aluOp = ALU_SUB;
                F_AND:         e.aluOp = ALU_AND;
                F_OR:          e.aluOp = ALU_OR;
                F_XOR:         e.aluOp = ALU_XOR;
                F_NOR:         e.aluOp = ALU_NOR;
                F_SLT:         e.aluOp = ALU_SLT;
                F_SLTU:        e.aluOp = ALU_SLTU;
                F_SLL:         e.aluOp = ALU_SLL;
                F_SRL:         e.aluOp = ALU_SRL;
                F_SRA:         e.aluOp = ALU_SRA;
                // undefined funct writes nothing
                default:       e.regWrite = 1'b0;
            endcase
        end
        LW, SW: begin
            e.aluSrc = 1'b1;
            e.aluOp = ALU_ADD;
            e.regWrite = (op == LW);
            e.memToReg = (op == LW);
            e.memWrite = (op == SW);
        end
        ADDI, ADDIU, SLTI, SLTIU, LUI: begin
            e.regWrite = 1'b1;
            e.aluSrc = 1'b1;
            e.aluOp = (op == SLTI) ? ALU_SLT : (op == SLTIU) ? ALU_SLTU :
                      (op == LUI) ? ALU_LUI : ALU_ADD;
        end
        ANDI, ORI, XORI: begin
            e.regWrite = 1'b1;
            e.aluSrc = 1'b1;
            e.aluOp = (op == ANDI) ? ALU_AND : (op == ORI) ? ALU_OR : ALU_XOR;
            e.immExt = {16'h0000, w.iFields.imm16};
        end
        BEQ, BNE, BGTZ, BLEZ: begin
            e.branch = 1'b1;
            e.aluOp = ALU_SUB;
            e.brCond = (op == BEQ) ? BR_EQ : (op == BNE) ? BR_NE :
                       (op == BGTZ) ? BR_GTZ : BR_LEZ;
        end
        REGIMM: begin
            e.branch = 1'b1;
            e.aluOp = ALU_SUB;
            // link forms also write r31
            e.bal = (w.iFields.rt == RT_BLTZAL) || (w.iFields.rt == RT_BGEZAL);
            e.regWrite = e.bal;
            dest = LINK_REG;
            if (w.iFields.rt == RT_BLTZ || w.iFields.rt == RT_BLTZAL)
                e.brCond = BR_LTZ;
            else if (w.iFields.rt == RT_BGEZ || w.iFields.rt == RT_BGEZAL)
                e.brCond = BR_GEZ;
        end
        J: e.jump = 1'b1;
        default: ;
    endcase
    e.writeReg = e.regWrite ? dest : 5'd0;
    return e;
endfunction

`endif

// File: testbench/tb_decodeUnit.sv
`timescale 1ns/1ns

module tb_decodeUnit import mipsDecodePkg::*; ();

    `include "decodeRef.svh"

    localparam int TIMEOUT_CYCLES = 20;

    logic        clk = 1'b0;
    logic        rst;
    logic        req;
    logic [31:0] instr;
    logic        ack;
    logic        regWrite, regDst, aluSrc, branch, bal, memWrite, memToReg, jump;
    aluOp_e      aluOp;
    branchCond_e brCond;
    logic [31:0] immExt;
    logic [4:0]  writeReg;

    int          mismatchCount;
    int          timeoutCount;
    int          protocolCount;
    instrWord_u  expWord;
    event        checkEvent;

    // stimulus tables
    opcode_e     definedOps [0:16] = '{RTYPE, REGIMM, J, BEQ, BNE, BLEZ, BGTZ, ADDI, ADDIU,
                                       SLTI, SLTIU, ANDI, ORI, XORI, LUI, LW, SW};
    funct_e      definedFuncts [0:12] = '{F_SLL, F_SRL, F_SRA, F_ADD, F_ADDU, F_SUB, F_SUBU,
                                          F_AND, F_OR, F_XOR, F_NOR, F_SLT, F_SLTU};
    logic [4:0]  regimmRts [0:4] = '{RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL, 5'h05};

    decodeUnit DUT (
        .clk (clk), .rst (rst), .req (req), .instr (instr), .ack (ack),
        .regWrite (regWrite), .regDst (regDst), .aluSrc (aluSrc), .branch (branch),
        .bal (bal), .memWrite (memWrite), .memToReg (memToReg), .jump (jump),
        .aluOp (aluOp), .brCond (brCond), .immExt (immExt), .writeReg (writeReg)
    );

    // 40 ns period
    always #20 clk = ~clk;

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatchCount++;
            $display("MISMATCH %s got 0x%h expected 0x%h (instr 0x%h)", name, got, exp, expWord);
        end
    endtask

    task automatic checkAlu(input aluOp_e got, input aluOp_e exp);
        if (got !== exp) begin
            mismatchCount++;
            $display("MISMATCH aluOp got 0x%h expected 0x%h (instr 0x%h)", got, exp, expWord);
        end
    endtask

    task automatic checkCond(input branchCond_e got, input branchCond_e exp);
        if (got !== exp) begin
            mismatchCount++;
            $display("MISMATCH brCond got 0x%h expected 0x%h (instr 0x%h)", got, exp, expWord);
        end
    endtask

    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatchCount++;
            $display("MISMATCH %s got 0x%h expected 0x%h (instr 0x%h)", name, got, exp, expWord);
        end
    endtask

    task automatic checkReg(input string name, input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            mismatchCount++;
            $display("MISMATCH %s got 0x%h expected 0x%h (instr 0x%h)", name, got, exp, expWord);
        end
    endtask

    // compares on request at a falling edge
    always @(checkEvent) begin : compareBlock
        decodeExp_t e;
        e = decodeRef(expWord);
        checkBit("regWrite", regWrite, e.regWrite);
        checkBit("regDst", regDst, e.regDst);
        checkBit("aluSrc", aluSrc, e.aluSrc);
        checkBit("branch", branch, e.branch);
        checkBit("bal", bal, e.bal);
        checkBit("memWrite", memWrite, e.memWrite);
        checkBit("memToReg", memToReg, e.memToReg);
        checkBit("jump", jump, e.jump);
        checkAlu(aluOp, e.aluOp);
        checkCond(brCond, e.brCond);
        checkWord("immExt", immExt, e.immExt);
        checkReg("writeReg", writeReg, e.writeReg);
    end

    // one four-phase transfer
    // holdCycles keeps req up with otherWord on the bus
    task automatic runTransaction(input logic [31:0] word, input int holdCycles,
                                  input logic [31:0] otherWord);
        int cycles;
        if (timeoutCount != 0)
            return;
        @(negedge clk);
        req = 1'b1;
        instr = word;
        cycles = 0;
        while (ack !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (ack !== 1'b1) begin
            timeoutCount++;
            $display("ack never rose after req for instruction 0x%h", word);
            return;
        end
        if (cycles != 1) begin
            protocolCount++;
            $display("ack rose %0d cycles after req instead of 1", cycles);
        end
        expWord = word;
        -> checkEvent;
        // new word under a held req must be ignored
        for (int i = 0; i < holdCycles; i++) begin
            instr = otherWord;
            @(negedge clk);
            if (ack !== 1'b1) begin
                protocolCount++;
                $display("ack dropped while req was still high");
            end
            -> checkEvent;
        end
        req = 1'b0;
        cycles = 0;
        while (ack !== 1'b0 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (ack !== 1'b0) begin
            timeoutCount++;
            $display("ack never fell after req was dropped");
            return;
        end
        if (cycles != 1) begin
            protocolCount++;
            $display("ack fell %0d cycles after req instead of 1", cycles);
        end
    endtask

    // mostly defined opcodes, functs and rt codes over random fields
    function automatic instrWord_u randomWord();
        instrWord_u w;
        int unsigned sel;
        w = $urandom();
        sel = $urandom % 16;
        if (sel < 14)
            w.iFields.op = definedOps[$urandom % 17];
        if (w.iFields.op == RTYPE && sel < 12)
            w.rFields.funct = definedFuncts[$urandom % 13];
        if (w.iFields.op == REGIMM && sel < 12)
            w.iFields.rt = regimmRts[$urandom % 4];
        return w;
    endfunction

    initial begin
        void'($urandom(24));
        mismatchCount = 0;
        timeoutCount = 0;
        protocolCount = 0;
        rst = 1'b1;
        req = 1'b0;
        instr = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // ack stays low after reset
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            if (ack !== 1'b0) begin
                protocolCount++;
                $display("ack went high before any request");
            end
        end
        // latched zero word decodes as a nop
        expWord = '0;
        -> checkEvent;

        // every non-REGIMM opcode with negative and positive imm16
        foreach (definedOps[i]) begin
            if (definedOps[i] != REGIMM) begin
                runTransaction({definedOps[i], 5'd7, 5'd12, 16'h9025}, 0, '0);
                runTransaction({definedOps[i], 5'd3, 5'd21, 16'h4824}, 0, '0);
            end
        end

        // r-type functs and then one undefined funct
        foreach (definedFuncts[i])
            runTransaction({RTYPE, 5'd4, 5'd5, 5'd17, 5'd2, definedFuncts[i]}, 0, '0);
        runTransaction({RTYPE, 5'd4, 5'd5, 5'd17, 5'd2, 6'h3f}, 0, '0);

        // REGIMM forms with an undefined rt as the last entry
        foreach (regimmRts[i])
            runTransaction({REGIMM, 5'd6, regimmRts[i], 16'hfff0}, 0, '0);

        // req held high with a different word underneath
        runTransaction({ADDI, 5'd1, 5'd2, 16'h0010}, 4, {SW, 5'd9, 5'd8, 16'h8000});

        for (int n = 0; n < 300; n++)
            runTransaction(randomWord(), 0, '0);

        $display("errors: %0d mismatches, %0d timeouts, %0d protocol",
                 mismatchCount, timeoutCount, protocolCount);
        if (mismatchCount == 0 && timeoutCount == 0 && protocolCount == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: design/decodeUnit.sv
`timescale 1ns/1ns

module decodeUnit import mipsDecodePkg::*; (
    input  logic        clk,
    input  logic        rst,
    // upstream four-phase handshake
    input  logic        req,
    input  logic [31:0] instr,
    output logic        ack,
    // decoded outputs valid while ack is high
    output logic        regWrite,
    output logic        regDst,
    output logic        aluSrc,
    output logic        branch,
    output logic        bal,
    output logic        memWrite,
    output logic        memToReg,
    output logic        jump,
    output aluOp_e      aluOp,
    output branchCond_e brCond,
    output logic [31:0] immExt,
    output logic [4:0]  writeReg
);

    instrWord_u instrLatched;
    logic       capture;
    logic       releaseAck;

    // new word only when idle and req is up
    assign capture = req && !ack;

    // req has dropped after our ack
    assign releaseAck = !req && ack;

    // ack is the only handshake state bit
    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else if (capture) begin
            ack <= 1'b1;
        end else if (releaseAck) begin
            ack <= 1'b0;
        end
    end

    // instruction latch
    // all-zero reset word is sll r0,r0,0 which acts as a nop
    always_ff @(posedge clk) begin
        if (rst) begin
            instrLatched <= '0;
        end else if (capture) begin
            instrLatched <= instr;
        end
    end

    // outputs follow the latched word combinationally
    // and hold until the next capture
    controller ctrl (
        .instr    (instrLatched),
        .regWrite (regWrite),
        .regDst   (regDst),
        .aluSrc   (aluSrc),
        .branch   (branch),
        .bal      (bal),
        .memWrite (memWrite),
        .memToReg (memToReg),
        .jump     (jump),
        .aluOp    (aluOp),
        .brCond   (brCond),
        .immExt   (immExt),
        .writeReg (writeReg)
    );

endmodule

// File: design/controller.sv
`timescale 1ns/1ns

module controller import mipsDecodePkg::*; (
    input  instrWord_u  instr,
    output logic        regWrite,
    output logic        regDst,
    output logic        aluSrc,
    output logic        branch,
    output logic        bal,
    output logic        memWrite,
    output logic        memToReg,
    output logic        jump,
    output aluOp_e      aluOp,
    output branchCond_e brCond,
    output logic [31:0] immExt,
    output logic [4:0]  writeReg
);

    // datapath control bits
    mainDecoder mainDec (
        .instr    (instr),
        .regWrite (regWrite),
        .regDst   (regDst),
        .aluSrc   (aluSrc),
        .branch   (branch),
        .bal      (bal),
        .memWrite (memWrite),
        .memToReg (memToReg),
        .jump     (jump)
    );

    // ALU operation
    aluDecoder aluDec (
        .instr (instr),
        .aluOp (aluOp)
    );

    // branch condition
    always_comb begin
        case (instr.iFields.op)
            BEQ:  brCond = BR_EQ;
            BNE:  brCond = BR_NE;
            BGTZ: brCond = BR_GTZ;
            BLEZ: brCond = BR_LEZ;
            REGIMM: begin
                // link forms test the same sign as their base
                case (instr.iFields.rt)
                    RT_BLTZ, RT_BLTZAL: brCond = BR_LTZ;
                    RT_BGEZ, RT_BGEZAL: brCond = BR_GEZ;
                    default:            brCond = BR_NONE;
                endcase
            end
            default: brCond = BR_NONE;
        endcase
    end

    // logical immediates zero-extend, the rest sign-extend
    always_comb begin
        case (instr.iFields.op)
            ANDI, ORI, XORI: immExt = {16'h0000, instr.iFields.imm16};
            default:         immExt = {{16{instr.iFields.imm16[15]}}, instr.iFields.imm16};
        endcase
    end

    // destination register, zero when nothing is written
    always_comb begin
        if (!regWrite)
            writeReg = 5'd0;
        else if (bal)
            writeReg = LINK_REG;
        else if (regDst)
            writeReg = instr.rFields.rd;
        else
            writeReg = instr.iFields.rt;
    end

endmodule

// File: design/aluDecoder.sv
`timescale 1ns/1ns

module aluDecoder import mipsDecodePkg::*; (
    input  instrWord_u instr,
    output aluOp_e     aluOp
);

    aluOp_e functOp;

    // r-type op from funct
    always_comb begin
        case (instr.rFields.funct)
            F_ADD, F_ADDU: functOp = ALU_ADD;
            F_SUB, F_SUBU: functOp = ALU_SUB;
            F_AND:         functOp = ALU_AND;
            F_OR:          functOp = ALU_OR;
            F_XOR:         functOp = ALU_XOR;
            F_NOR:         functOp = ALU_NOR;
            F_SLT:         functOp = ALU_SLT;
            F_SLTU:        functOp = ALU_SLTU;
            F_SLL:         functOp = ALU_SLL;
            F_SRL:         functOp = ALU_SRL;
            F_SRA:         functOp = ALU_SRA;
            // unsupported funct
            default:       functOp = ALU_NONE;
        endcase
    end

    // opcode class first, funct only under RTYPE
    always_comb begin
        case (instr.iFields.op)
            RTYPE: aluOp = functOp;

            // address calc and add-immediate
            LW, SW,
            ADDI, ADDIU: aluOp = ALU_ADD;

            // logic and compare immediates
            ANDI:  aluOp = ALU_AND;
            ORI:   aluOp = ALU_OR;
            XORI:  aluOp = ALU_XOR;
            SLTI:  aluOp = ALU_SLT;
            SLTIU: aluOp = ALU_SLTU;
            LUI:   aluOp = ALU_LUI;

            // branches compare by subtraction
            BEQ, BNE, BGTZ, BLEZ,
            REGIMM: aluOp = ALU_SUB;

            // j and anything undefined
            default: aluOp = ALU_NONE;
        endcase
    end

endmodule

// File: design/mainDecoder.sv
`timescale 1ns/1ns

module mainDecoder import mipsDecodePkg::*; (
    input  instrWord_u instr,
    output logic       regWrite,
    output logic       regDst,
    output logic       aluSrc,
    output logic       branch,
    output logic       bal,
    output logic       memWrite,
    output logic       memToReg,
    output logic       jump
);

    logic functOk;
    logic linkForm;

    // funct is one of the r-type ops we support
    always_comb begin
        case (instr.rFields.funct)
            F_SLL, F_SRL, F_SRA,
            F_ADD, F_ADDU, F_SUB, F_SUBU,
            F_AND, F_OR, F_XOR, F_NOR,
            F_SLT, F_SLTU: functOk = 1'b1;
            default:       functOk = 1'b0;
        endcase
    end

    // bltzal / bgezal write the return address
    assign linkForm = (instr.iFields.op == REGIMM) &&
                      (instr.iFields.rt == RT_BLTZAL || instr.iFields.rt == RT_BGEZAL);

    // regWrite
    always_comb begin
        case (instr.iFields.op)
            RTYPE:   regWrite = functOk;
            LW,
            ADDI, ADDIU, SLTI, SLTIU,
            ANDI, ORI, XORI, LUI:  regWrite = 1'b1;
            REGIMM:  regWrite = linkForm;
            default: regWrite = 1'b0;
        endcase
    end

    // regDst, rd only for r-type
    assign regDst = (instr.rFields.op == RTYPE);

    // aluSrc picks the immediate
    always_comb begin
        case (instr.iFields.op)
            LW, SW,
            ADDI, ADDIU, SLTI, SLTIU,
            ANDI, ORI, XORI, LUI: aluSrc = 1'b1;
            default:              aluSrc = 1'b0;
        endcase
    end

    // branch and bal
    always_comb begin
        case (instr.iFields.op)
            BEQ, BNE, BGTZ, BLEZ: begin
                branch = 1'b1;
                bal    = 1'b0;
            end
            REGIMM: begin
                branch = 1'b1;
                bal    = linkForm;
            end
            default: begin
                branch = 1'b0;
                bal    = 1'b0;
            end
        endcase
    end

    // memory side
    assign memWrite = (instr.iFields.op == SW);
    assign memToReg = (instr.iFields.op == LW);

    // plain j only, no jal here
    assign jump = (instr.iFields.op == J);

endmodule

// File: design/mipsDecodePkg.sv
package mipsDecodePkg;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        RTYPE  = 6'h00,
        REGIMM = 6'h01,
        J      = 6'h02,
        BEQ    = 6'h04,
        BNE    = 6'h05,
        BLEZ   = 6'h06,
        BGTZ   = 6'h07,
        ADDI   = 6'h08,
        ADDIU  = 6'h09,
        SLTI   = 6'h0a,
        SLTIU  = 6'h0b,
        ANDI   = 6'h0c,
        ORI    = 6'h0d,
        XORI   = 6'h0e,
        LUI    = 6'h0f,
        LW     = 6'h23,
        SW     = 6'h2b
    } opcode_e;

    // funct field of r-type words, instr[5:0]
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SRA  = 6'h03,
        F_ADD  = 6'h20,
        F_ADDU = 6'h21,
        F_SUB  = 6'h22,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_e;

    // rt codes under the REGIMM opcode
    localparam logic [4:0] RT_BLTZ   = 5'h00;
    localparam logic [4:0] RT_BGEZ   = 5'h01;
    localparam logic [4:0] RT_BLTZAL = 5'h10;
    localparam logic [4:0] RT_BGEZAL = 5'h11;

    // return address register for the link branches
    localparam logic [4:0] LINK_REG = 5'd31;

    // operation handed to the ALU
    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_AND  = 4'h2,
        ALU_OR   = 4'h3,
        ALU_XOR  = 4'h4,
        ALU_NOR  = 4'h5,
        ALU_SLT  = 4'h6,
        ALU_SLTU = 4'h7,
        ALU_SLL  = 4'h8,
        ALU_SRL  = 4'h9,
        ALU_SRA  = 4'ha,
        ALU_LUI  = 4'hb,
        ALU_NONE = 4'hf
    } aluOp_e;

    // condition the branch unit tests
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_GTZ  = 3'd3,
        BR_LEZ  = 3'd4,
        BR_LTZ  = 3'd5,
        BR_GEZ  = 3'd6
    } branchCond_e;

    // one instruction word, seen as r-format or i-format
    typedef union packed {
        struct packed {
            opcode_e    op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            funct_e     funct;
        } rFields;
        struct packed {
            opcode_e     op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } iFields;
    } instrWord_u;

endpackage
